// ==== design/cim_params.svh ====
// array geometry and field width constants for the CIM S-box sequencer
`ifndef CIM_PARAMS_SVH
`define CIM_PARAMS_SVH

// --------------------------------------------------
// array geometry
// --------------------------------------------------

// byte-wide banks in the array
`define CIM_NUM_BANKS   16
// address groups per run
`define CIM_NUM_GROUPS  11
// READ cycles per group, one per bit-plane
`define CIM_NUM_PLANES  8

// --------------------------------------------------
// field widths
// --------------------------------------------------

`define CIM_BLOCK_W     128
`define CIM_SLICE_W     16
`define CIM_DEMUX_W     3
`define CIM_ROW_W       6

`endif

// ==== design/cim_pkg.sv ====
// types for bank addresses, key bytes, sequencer phase and bank buses
`include "cim_params.svh"

package cim_pkg;

    // --------------------------------------------------
    // bank addressing
    // --------------------------------------------------

    // one bank's array address
    typedef struct packed {
        logic [`CIM_DEMUX_W-1:0] demux;
        logic [`CIM_ROW_W-1:0]   rwl;
    } bank_addr_t;

    // gathered key byte, also used as a lookup address
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [`CIM_DEMUX_W-2:0] col;
            logic [`CIM_ROW_W-1:0]   row;
        } lut;
    } key_byte_u;

    // --------------------------------------------------
    // sequencer phase
    // --------------------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        READ,
        LOOKUP,
        OUT
    } seq_state_e;

    typedef struct packed {
        seq_state_e state;
        logic [3:0] grp;
        logic [2:0] plane;
    } seq_phase_t;

    // bank 0 in the low byte
    typedef logic [`CIM_NUM_BANKS-1:0][7:0] bank_bytes_t;
    typedef bank_addr_t [`CIM_NUM_BANKS-1:0] bank_addr_bus_t;

endpackage

// ==== design/cim_sequencer.sv ====
// FSM stepping READ/LOOKUP/OUT with group and plane counters, done pulse
`timescale 1ns/1ps
`include "cim_params.svh"

module cim_sequencer
    import cim_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       en,
    input  logic       start,
    output seq_phase_t phase,
    output logic       done
);

    localparam logic [2:0] LAST_PLANE = 3'(`CIM_NUM_PLANES - 1);
    localparam logic [3:0] LAST_GROUP = 4'(`CIM_NUM_GROUPS - 1);

    seq_phase_t phase_d;
    logic       done_d;

    // --------------------------------------------------
    // next phase
    // --------------------------------------------------
    always_comb begin
        phase_d = phase;
        done_d  = 1'b0;
        case (phase.state)
            IDLE: begin
                if (start) begin
                    phase_d.state = READ;
                    phase_d.grp   = '0;
                    phase_d.plane = '0;
                end
            end
            READ: begin
                if (phase.plane == LAST_PLANE) begin
                    phase_d.state = LOOKUP;
                    phase_d.plane = '0;
                end else begin
                    phase_d.plane = phase.plane + 3'd1;
                end
            end
            LOOKUP: begin
                // last group goes to OUT, done rises with it
                if (phase.grp == LAST_GROUP) begin
                    phase_d.state = OUT;
                    done_d        = 1'b1;
                end else begin
                    phase_d.state = READ;
                    phase_d.grp   = phase.grp + 4'd1;
                end
            end
            default: begin
                phase_d.state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            phase <= '{state: IDLE, grp: '0, plane: '0};
            done  <= 1'b0;
        end else if (en) begin
            phase <= phase_d;
            done  <= done_d;
        end
    end

    // plane wraps into LOOKUP, never past the last plane
    a_plane_wrap: assert property (@(posedge CLK) disable iff (rst)
        (en && phase.state == READ && phase.plane == LAST_PLANE)
        |=> (phase.state == LOOKUP && phase.plane == '0));

    a_grp_range: assert property (@(posedge CLK) disable iff (rst)
        phase.grp <= LAST_GROUP);

endmodule

// ==== design/cim_plane_gather.sv ====
// bit-plane gather into key bytes and per-bank address register
`timescale 1ns/1ps
`include "cim_params.svh"

module cim_plane_gather
    import cim_pkg::*;
(
    input  logic           CLK,
    input  logic           rst,
    input  logic           en,
    input  seq_phase_t     phase,
    input  bank_bytes_t    rio,
    output bank_addr_bus_t bank_addr
);

    localparam int HALF = `CIM_NUM_BANKS / 2;

    key_byte_u [`CIM_NUM_BANKS-1:0] key_q;
    logic [2:0]                     bit_sel;
    logic [HALF-1:0]                plane_lo;
    logic [HALF-1:0]                plane_hi;
    bank_addr_t                     grp_addr;

    // --------------------------------------------------
    // bit-plane gather
    // --------------------------------------------------

    // msb plane first
    assign bit_sel = 3'(`CIM_NUM_PLANES - 1) - phase.plane;

    always_comb begin
        for (int b = 0; b < HALF; b++) begin
            plane_lo[b] = rio[b][bit_sel];
            plane_hi[b] = rio[b + HALF][bit_sel];
        end
    end

    // plane p fills key bytes 2p and 2p+1
    always_ff @(posedge CLK) begin
        if (en && phase.state == READ) begin
            key_q[{phase.plane, 1'b0}].raw <= plane_lo;
            key_q[{phase.plane, 1'b1}].raw <= plane_hi;
        end
    end

    // --------------------------------------------------
    // address generation
    // --------------------------------------------------

    // group code: demux 7 - (g mod 4), row g div 4
    assign grp_addr.demux = {1'b1, ~phase.grp[1:0]};
    assign grp_addr.rwl   = {4'b0000, phase.grp[3:2]};

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            bank_addr <= '0;
        end else if (en) begin
            case (phase.state)
                READ: begin
                    bank_addr <= {`CIM_NUM_BANKS{grp_addr}};
                end
                LOOKUP: begin
                    for (int i = 0; i < `CIM_NUM_BANKS; i++) begin
                        bank_addr[i].demux <= {1'b0, key_q[i].lut.col};
                        bank_addr[i].rwl   <= key_q[i].lut.row;
                    end
                end
                default: begin
                    // hold in IDLE and OUT
                    bank_addr <= bank_addr;
                end
            endcase
        end
    end

    // lookup addresses stay in the lower half of the demux range
    for (genvar i = 0; i < `CIM_NUM_BANKS; i++) begin : g_msb_chk
        a_lookup_msb: assert property (@(posedge CLK) disable iff (rst)
            (en && phase.state == LOOKUP) |=> !bank_addr[i].demux[`CIM_DEMUX_W-1]);
    end

endmodule

// ==== design/cim_state_stream.sv ====
// S-box result capture, state source select and word-line slice output
`timescale 1ns/1ps
`include "cim_params.svh"

module cim_state_stream
    import cim_pkg::*;
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    en,
    input  seq_phase_t              phase,
    input  logic [`CIM_BLOCK_W-1:0] din,
    input  bank_bytes_t             rio,
    output logic [`CIM_SLICE_W-1:0] wl_in,
    output bank_bytes_t             sub_state
);

    logic [`CIM_NUM_PLANES-1:0][`CIM_SLICE_W-1:0] src;
    logic [2:0]                                   slice_sel;

    // --------------------------------------------------
    // source select
    // --------------------------------------------------

    // group 0 streams the input block, later groups the last lookup result
    assign src = (phase.grp == '0) ? din : sub_state;

    // top slice on plane 0
    assign slice_sel = 3'(`CIM_NUM_PLANES - 1) - phase.plane;

    // --------------------------------------------------
    // word-line slice
    // --------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            wl_in <= '0;
        end else if (en) begin
            if (phase.state == READ) begin
                wl_in <= src[slice_sel];
            end else begin
                wl_in <= '0;
            end
        end
    end

    // --------------------------------------------------
    // S-box result
    // --------------------------------------------------

    // bank i returns substituted byte i in the LOOKUP cycle
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            sub_state <= '0;
        end else if (en && phase.state == LOOKUP) begin
            sub_state <= rio;
        end
    end

endmodule

// ==== design/cim_sbox_top.sv ====
// top level of the CIM S-box sequencer: sequencer, gather and stream stages
`timescale 1ns/1ps
`include "cim_params.svh"

module cim_sbox_top
    import cim_pkg::*;
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    start,
    input  logic [`CIM_BLOCK_W-1:0] din,
    input  bank_bytes_t             rio,
    output bank_addr_bus_t          bank_addr,
    output logic [`CIM_SLICE_W-1:0] wl_in,
    output bank_bytes_t             sub_state,
    output logic                    done
);

    seq_phase_t phase;

    // decode
    cim_sequencer i_sequencer (
        .CLK   (CLK),
        .rst   (rst),
        .en    (en),
        .start (start),
        .phase (phase),
        .done  (done)
    );

    // execute
    cim_plane_gather i_gather (
        .CLK       (CLK),
        .rst       (rst),
        .en        (en),
        .phase     (phase),
        .rio       (rio),
        .bank_addr (bank_addr)
    );

    // result
    cim_state_stream i_stream (
        .CLK       (CLK),
        .rst       (rst),
        .en        (en),
        .phase     (phase),
        .din       (din),
        .rio       (rio),
        .wl_in     (wl_in),
        .sub_state (sub_state)
    );

endmodule

// ==== dv/tb_cim_sbox.sv ====
// directed testbench for the CIM S-box sequencer with a random bank read model
`timescale 1ns/1ps
`include "cim_params.svh"

module tb_cim_sbox
    import cim_pkg::*;
();

    logic                    CLK;
    logic                    rst;
    logic                    en;
    logic                    start;
    logic [`CIM_BLOCK_W-1:0] din;
    bank_bytes_t             rio;
    bank_addr_bus_t          bank_addr;
    logic [`CIM_SLICE_W-1:0] wl_in;
    bank_bytes_t             sub_state;
    logic                    done;

    int errors;
    int tests;

    // rio seen at each READ edge of the current group
    bank_bytes_t plane_rio [`CIM_NUM_PLANES];

    cim_sbox_top i_dut (
        .CLK       (CLK),
        .rst       (rst),
        .en        (en),
        .start     (start),
        .din       (din),
        .rio       (rio),
        .bank_addr (bank_addr),
        .wl_in     (wl_in),
        .sub_state (sub_state),
        .done      (done)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic drive_rio();
        rio = {$urandom, $urandom, $urandom, $urandom};
    endtask

    task automatic check_eq(input logic [143:0] got, input logic [143:0] exp,
                            input string what);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    // demux is 7 - (g mod 4) and row is g div 4
    function automatic logic [8:0] group_addr(input int g);
        return {3'(7 - g % 4), 6'(g / 4)};
    endfunction

    // key byte 2p gathers bit 7-p of banks 0..7 and key byte 2p+1 of banks 8..15
    function automatic logic [8:0] lookup_addr(input int bank);
        logic [7:0] key;
        int         p;
        int         half;
        p    = bank / 2;
        half = (bank % 2) * 8;
        for (int b = 0; b < 8; b++) begin
            key[b] = plane_rio[p][half + b][7 - p];
        end
        return {1'b0, key[7:6], key[5:0]};
    endfunction

    // --------------------------------------------------
    // one full run with an optional stall before active edge stall_at
    // --------------------------------------------------
    task automatic run_block(input logic [`CIM_BLOCK_W-1:0] blk, input int stall_at,
                             input int stall_len);
        logic [`CIM_BLOCK_W-1:0] src;
        bank_addr_bus_t          addr_snap;
        logic [`CIM_SLICE_W-1:0] wl_snap;
        bank_bytes_t             sub_snap;
        int                      t;
        int                      edges;
        int                      k;
        int                      g;
        int                      p;
        t     = 0;
        edges = 0;
        src   = blk;
        din   = blk;
        start = 1'b1;
        drive_rio();
        while (!done && edges < 200) begin
            if (t + 1 == stall_at) begin
                en        = 1'b0;
                addr_snap = bank_addr;
                wl_snap   = wl_in;
                sub_snap  = sub_state;
                for (int s = 0; s < stall_len; s++) begin
                    next_cycle();
                    edges++;
                    check_eq(bank_addr, addr_snap, "bank_addr during stall");
                    check_eq(wl_in, wl_snap, "wl_in during stall");
                    check_eq(sub_state, sub_snap, "sub_state during stall");
                    check_eq(done, 1'b0, "done during stall");
                    drive_rio();
                end
                en = 1'b1;
            end
            next_cycle();
            edges++;
            t++;
            start = 1'b0;
            k = t - 2;
            g = k / 9;
            p = k % 9;
            if (t == 1) begin
                check_eq(wl_in, '0, "wl_in after start");
            end else if (p < `CIM_NUM_PLANES) begin
                plane_rio[p] = rio;
                for (int i = 0; i < `CIM_NUM_BANKS; i++) begin
                    check_eq(bank_addr[i], group_addr(g), "READ bank address");
                end
                check_eq(wl_in, src[`CIM_BLOCK_W - 1 - `CIM_SLICE_W * p -: `CIM_SLICE_W],
                         "READ wl_in slice");
            end else begin
                check_eq(sub_state, rio, "sub_state after LOOKUP");
                check_eq(wl_in, '0, "wl_in after LOOKUP");
                for (int i = 0; i < `CIM_NUM_BANKS; i++) begin
                    check_eq(bank_addr[i], lookup_addr(i), "LOOKUP bank address");
                end
                // next group streams this result
                src = rio;
            end
            drive_rio();
        end
        if (!done) begin
            $display("timeout: done did not rise within %0d cycles of start", edges);
            errors++;
        end else begin
            check_eq(t, 100, "active cycles from start to done");
            check_eq(edges, 100 + stall_len, "cycles from start to done");
            check_eq(sub_state, src, "sub_state at done");
            next_cycle();
            check_eq(done, 1'b0, "done one cycle after pulse");
        end
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------

    task automatic test_reset();
        int err_start;
        err_start = errors;
        for (int c = 0; c < 3; c++) begin
            check_eq(bank_addr, '0, "bank_addr after reset");
            check_eq(wl_in, '0, "wl_in after reset");
            check_eq(sub_state, '0, "sub_state after reset");
            check_eq(done, 1'b0, "done after reset");
            next_cycle();
        end
        report_test("reset", err_start);
    endtask

    task automatic test_run();
        int err_start;
        err_start = errors;
        run_block({$urandom, $urandom, $urandom, $urandom}, 0, 0);
        run_block({$urandom, $urandom, $urandom, $urandom}, 0, 0);
        report_test("run", err_start);
    endtask

    task automatic test_stall();
        int err_start;
        err_start = errors;
        // lands on the LOOKUP edge of group 4
        run_block({$urandom, $urandom, $urandom, $urandom}, 46, 6);
        report_test("stall", err_start);
    endtask

    initial begin
        void'($urandom(32'h1b77_14e4));
        errors = 0;
        tests  = 0;
        rst    = 1'b1;
        en     = 1'b0;
        start  = 1'b0;
        din    = '0;
        rio    = '0;
        repeat (5) @(posedge CLK);
        #1;
        rst = 1'b0;
        en  = 1'b1;
        test_reset();
        test_run();
        test_stall();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== cim_sbox_top.f ====
+incdir+design
design/cim_pkg.sv
design/cim_sequencer.sv
design/cim_plane_gather.sv
design/cim_state_stream.sv
design/cim_sbox_top.sv
dv/tb_cim_sbox.sv

// ==== Makefile ====
# Verilator build for the CIM S-box sequencer

VERILATOR ?= verilator
FLIST     ?= cim_sbox_top.f
TB_TOP    ?= tb_cim_sbox
RTL_TOP   ?= cim_sbox_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
